/* logic/bbox_pkg.sv */
// Shared widths, types and helpers for the bounding-box stage
// Coordinates are two's complement fixed point with RADIX fraction bits
// Colors are unsigned and pass through untouched
// The sample grid never goes finer than an eighth of a pixel
// RADIX must be at least 3 for the 64x mode to make sense
package bbox_pkg;

    // Bits in every coordinate and color word
    parameter int SIGFIG = 24;
    // Fraction bits in a coordinate
    parameter int RADIX  = 10;
    // Vertices per triangle
    parameter int VERTS  = 3;
    // Color channels per triangle
    parameter int COLORS = 3;

    // Signed fixed-point coordinate
    typedef logic signed [SIGFIG-1:0] coord_t;

    // Unsigned color channel
    typedef logic [SIGFIG-1:0] color_t;

    // Sample grid selection
    // 1x is one sample per pixel, 64x is an eighth of a pixel per side
    typedef enum logic [1:0] {
        MSAA_1X  = 2'd0,
        MSAA_4X  = 2'd1,
        MSAA_16X = 2'd2,
        MSAA_64X = 2'd3
    } msaa_t;

    // Word carried through the register pipeline
    // Nine vertex coordinates, three colors and the clipped box
    typedef struct packed {
        coord_t [VERTS-1:0]  tri_x;
        coord_t [VERTS-1:0]  tri_y;
        coord_t [VERTS-1:0]  tri_z;
        color_t [COLORS-1:0] color;
        coord_t              ll_x;
        coord_t              ll_y;
        coord_t              ur_x;
        coord_t              ur_y;
    } pipe_word_t;

    // Mask that floors a coordinate to the grid of the given mode
    // Integer bits always survive, only the low fraction bits are cleared
    function automatic coord_t grid_mask(msaa_t mode);
        int     drop;
        coord_t mask;
        // Default to whole pixels
        drop = RADIX;
        case (mode)
            MSAA_1X:  drop = RADIX;
            MSAA_4X:  drop = RADIX - 1;
            MSAA_16X: drop = RADIX - 2;
            MSAA_64X: drop = RADIX - 3;
            default:  drop = RADIX;
        endcase
        // All ones shifted up leaves zeros in the dropped positions
        mask = '1;
        mask = mask << drop;
        return mask;
    endfunction

endpackage

/* logic/bbox_extent.sv */
// Combinational corner search for one triangle
// Lower-left is the per-axis minimum, upper-right the per-axis maximum
// Both corners are floored toward minus infinity onto the sample grid
// Flooring a negative coordinate moves it further from zero
// No clamping happens here, corners may lie off screen
`timescale 1ns/1ps

module bbox_extent (
    input  bbox_pkg::coord_t tri_x [bbox_pkg::VERTS],
    input  bbox_pkg::coord_t tri_y [bbox_pkg::VERTS],
    input  bbox_pkg::msaa_t  sample_mode,
    output bbox_pkg::coord_t ll_x,
    output bbox_pkg::coord_t ll_y,
    output bbox_pkg::coord_t ur_x,
    output bbox_pkg::coord_t ur_y
);
    import bbox_pkg::*;

    // Raw extremes before flooring
    coord_t min_x;
    coord_t max_x;
    coord_t min_y;
    coord_t max_y;

    // Grid mask for the active sample mode
    coord_t mask;

    // Running min/max over the vertices
    always_comb begin
        // Seed with vertex zero
        min_x = tri_x[0];
        max_x = tri_x[0];
        min_y = tri_y[0];
        max_y = tri_y[0];
        for (int v = 1; v < VERTS; v++) begin
            // Signed compares, coordinates may be negative
            if (tri_x[v] < min_x) begin
                min_x = tri_x[v];
            end
            if (tri_x[v] > max_x) begin
                max_x = tri_x[v];
            end
            if (tri_y[v] < min_y) begin
                min_y = tri_y[v];
            end
            if (tri_y[v] > max_y) begin
                max_y = tri_y[v];
            end
        end
    end

    // Mode changes only between triangles
    assign mask = grid_mask(sample_mode);

    // Two's complement AND floors toward minus infinity
    assign ll_x = min_x & mask;
    assign ll_y = min_y & mask;

    // Upper-right floors too, so a sample exactly on the edge stays in
    assign ur_x = max_x & mask;
    assign ur_y = max_y & mask;

endmodule

/* logic/bbox_clip.sv */
// Clamps a floored box to the visible screen
// Screen spans zero up to screen_w and screen_h inclusive
// keep drops boxes that do not overlap the screen at all
// keep ignores the triangle's valid, the caller gates it
// Screen size is expected positive and already on the grid
`timescale 1ns/1ps

module bbox_clip (
    input  bbox_pkg::coord_t ll_x,
    input  bbox_pkg::coord_t ll_y,
    input  bbox_pkg::coord_t ur_x,
    input  bbox_pkg::coord_t ur_y,
    input  bbox_pkg::coord_t screen_w,
    input  bbox_pkg::coord_t screen_h,
    output bbox_pkg::coord_t clip_ll_x,
    output bbox_pkg::coord_t clip_ll_y,
    output bbox_pkg::coord_t clip_ur_x,
    output bbox_pkg::coord_t clip_ur_y,
    output logic             keep
);

    // Corner sits left of or below the origin
    logic ll_x_neg;
    logic ll_y_neg;

    // Corner sits right of or above the screen edge
    logic ur_x_over;
    logic ur_y_over;

    // Overlap tests on the clamped box
    logic x_overlap;
    logic y_overlap;

    assign ll_x_neg  = ll_x < 0;
    assign ll_y_neg  = ll_y < 0;
    assign ur_x_over = ur_x > screen_w;
    assign ur_y_over = ur_y > screen_h;

    // Lower-left clamps to zero
    assign clip_ll_x = ll_x_neg ? '0 : ll_x;
    assign clip_ll_y = ll_y_neg ? '0 : ll_y;

    // Upper-right clamps to the screen size
    assign clip_ur_x = ur_x_over ? screen_w : ur_x;
    assign clip_ur_y = ur_y_over ? screen_h : ur_y;

    // Box wholly left/below gives ur <= 0
    // Box wholly right/above gives ll >= screen
    assign x_overlap = (clip_ur_x > 0) && (clip_ll_x < screen_w);
    assign y_overlap = (clip_ur_y > 0) && (clip_ll_y < screen_h);

    assign keep = x_overlap && y_overlap;

endmodule

/* logic/bbox_pipe.sv */
// Elastic valid/ready register pipeline
// A stage loads when empty or when its own word leaves this cycle
// Bubbles collapse, a full chain with out_ready low stalls in place
// Ready ripples combinationally from out_ready back to in_ready
// Latency is PIPE_DEPTH cycles from input to output transfer, no stall
// PIPE_DEPTH must be 1 or more
`timescale 1ns/1ps

module bbox_pipe #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  bbox_pkg::pipe_word_t in_word,
    output logic                 out_valid,
    input  logic                 out_ready,
    output bbox_pkg::pipe_word_t out_word
);
    import bbox_pkg::*;

    // Stage registers, index 0 is nearest the input
    pipe_word_t            word_q [PIPE_DEPTH];
    logic [PIPE_DEPTH-1:0] valid_q;

    // What each stage would load, taken from the stage before it
    pipe_word_t            prev_word [PIPE_DEPTH];
    logic [PIPE_DEPTH-1:0] prev_valid;

    // Stage can accept this cycle
    logic [PIPE_DEPTH-1:0] stage_ready;

    // Feed of each stage
    always_comb begin
        prev_valid[0] = in_valid;
        prev_word[0]  = in_word;
        for (int s = 1; s < PIPE_DEPTH; s++) begin
            prev_valid[s] = valid_q[s-1];
            prev_word[s]  = word_q[s-1];
        end
    end

    // Ready chain, walked from the output end backwards
    always_comb begin
        stage_ready[PIPE_DEPTH-1] = !valid_q[PIPE_DEPTH-1] || out_ready;
        for (int s = PIPE_DEPTH - 2; s >= 0; s--) begin
            stage_ready[s] = !valid_q[s] || stage_ready[s+1];
        end
    end

    // Valid flags
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            for (int s = 0; s < PIPE_DEPTH; s++) begin
                // Loading an empty feed leaves a bubble behind
                if (stage_ready[s]) begin
                    valid_q[s] <= prev_valid[s];
                end
            end
        end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk) begin
        for (int s = 0; s < PIPE_DEPTH; s++) begin
            if (stage_ready[s] && prev_valid[s]) begin
                word_q[s] <= prev_word[s];
            end
        end
    end

    assign in_ready  = stage_ready[0];
    assign out_valid = valid_q[PIPE_DEPTH-1];
    assign out_word  = word_q[PIPE_DEPTH-1];

endmodule

/* logic/bbox_unit.sv */
// Bounding-box stage of the rasterizer
// One triangle per valid/ready transfer on the input side
// screen_w, screen_h and sample_mode must hold while triangles are inside
// An off-screen triangle is accepted but produces no output
// Kept triangles leave in order, PIPE_DEPTH cycles after entry without stall
`timescale 1ns/1ps

module bbox_unit #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  bbox_pkg::coord_t tri_x [bbox_pkg::VERTS],
    input  bbox_pkg::coord_t tri_y [bbox_pkg::VERTS],
    input  bbox_pkg::coord_t tri_z [bbox_pkg::VERTS],
    input  bbox_pkg::color_t color [bbox_pkg::COLORS],
    input  bbox_pkg::coord_t screen_w,
    input  bbox_pkg::coord_t screen_h,
    input  bbox_pkg::msaa_t  sample_mode,
    output logic             out_valid,
    input  logic             out_ready,
    output bbox_pkg::coord_t out_tri_x [bbox_pkg::VERTS],
    output bbox_pkg::coord_t out_tri_y [bbox_pkg::VERTS],
    output bbox_pkg::coord_t out_tri_z [bbox_pkg::VERTS],
    output bbox_pkg::color_t out_color [bbox_pkg::COLORS],
    output bbox_pkg::coord_t box_ll_x,
    output bbox_pkg::coord_t box_ll_y,
    output bbox_pkg::coord_t box_ur_x,
    output bbox_pkg::coord_t box_ur_y
);
    import bbox_pkg::*;

    // Floored corners, possibly off screen
    coord_t ext_ll_x;
    coord_t ext_ll_y;
    coord_t ext_ur_x;
    coord_t ext_ur_y;

    // Corners after clamping
    coord_t clip_ll_x;
    coord_t clip_ll_y;
    coord_t clip_ur_x;
    coord_t clip_ur_y;
    logic   keep;

    // Pipeline side
    logic       pipe_in_valid;
    pipe_word_t pipe_in_word;
    pipe_word_t pipe_out_word;

    bbox_extent u_extent (
        .tri_x       (tri_x),
        .tri_y       (tri_y),
        .sample_mode (sample_mode),
        .ll_x        (ext_ll_x),
        .ll_y        (ext_ll_y),
        .ur_x        (ext_ur_x),
        .ur_y        (ext_ur_y)
    );

    bbox_clip u_clip (
        .ll_x      (ext_ll_x),
        .ll_y      (ext_ll_y),
        .ur_x      (ext_ur_x),
        .ur_y      (ext_ur_y),
        .screen_w  (screen_w),
        .screen_h  (screen_h),
        .clip_ll_x (clip_ll_x),
        .clip_ll_y (clip_ll_y),
        .clip_ur_x (clip_ur_x),
        .clip_ur_y (clip_ur_y),
        .keep      (keep)
    );

    // Rejected triangle still handshakes but never enters the pipe
    assign pipe_in_valid = in_valid && keep;

    // Pack triangle, color and clipped box
    always_comb begin
        for (int v = 0; v < VERTS; v++) begin
            pipe_in_word.tri_x[v] = tri_x[v];
            pipe_in_word.tri_y[v] = tri_y[v];
            pipe_in_word.tri_z[v] = tri_z[v];
        end
        for (int c = 0; c < COLORS; c++) begin
            pipe_in_word.color[c] = color[c];
        end
        pipe_in_word.ll_x = clip_ll_x;
        pipe_in_word.ll_y = clip_ll_y;
        pipe_in_word.ur_x = clip_ur_x;
        pipe_in_word.ur_y = clip_ur_y;
    end

    bbox_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_pipe (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (pipe_in_valid),
        .in_ready  (in_ready),
        .in_word   (pipe_in_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (pipe_out_word)
    );

    // Unpack the last stage onto the output ports
    always_comb begin
        for (int v = 0; v < VERTS; v++) begin
            out_tri_x[v] = pipe_out_word.tri_x[v];
            out_tri_y[v] = pipe_out_word.tri_y[v];
            out_tri_z[v] = pipe_out_word.tri_z[v];
        end
        for (int c = 0; c < COLORS; c++) begin
            out_color[c] = pipe_out_word.color[c];
        end
    end

    assign box_ll_x = pipe_out_word.ll_x;
    assign box_ll_y = pipe_out_word.ll_y;
    assign box_ur_x = pipe_out_word.ur_x;
    assign box_ur_y = pipe_out_word.ur_y;

endmodule

/* tests/bbox_checker.sv */
// Protocol and range checks on the output side of bbox_unit
// Screen size is taken from the configuration ports, assumed stable
// Bound into every bbox_unit instance
`timescale 1ns/1ps

module bbox_checker (
    input logic             clk,
    input logic             rst,
    input logic             out_valid,
    input logic             out_ready,
    input bbox_pkg::coord_t out_tri_x [bbox_pkg::VERTS],
    input bbox_pkg::coord_t out_tri_y [bbox_pkg::VERTS],
    input bbox_pkg::coord_t out_tri_z [bbox_pkg::VERTS],
    input bbox_pkg::color_t out_color [bbox_pkg::COLORS],
    input bbox_pkg::coord_t box_ll_x,
    input bbox_pkg::coord_t box_ll_y,
    input bbox_pkg::coord_t box_ur_x,
    input bbox_pkg::coord_t box_ur_y,
    input bbox_pkg::coord_t screen_w,
    input bbox_pkg::coord_t screen_h
);
    import bbox_pkg::*;

    // Failed assertions, read by the testbench
    int assert_fails = 0;

    // All outputs in one vector for the stability check
    pipe_word_t out_bundle;

    always_comb begin
        for (int v = 0; v < VERTS; v++) begin
            out_bundle.tri_x[v] = out_tri_x[v];
            out_bundle.tri_y[v] = out_tri_y[v];
            out_bundle.tri_z[v] = out_tri_z[v];
        end
        for (int c = 0; c < COLORS; c++) begin
            out_bundle.color[c] = out_color[c];
        end
        out_bundle.ll_x = box_ll_x;
        out_bundle.ll_y = box_ll_y;
        out_bundle.ur_x = box_ur_x;
        out_bundle.ur_y = box_ur_y;
    end

    // One reset edge must already have cleared the valid flags
    a_reset_idle: assert property (@(posedge clk) rst && $past(rst) |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            assert_fails++;
        end

    // Stalled output holds still
    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_bundle))
        else begin
            $error("output changed while stalled");
            assert_fails++;
        end

    // Box is ordered and inside the screen
    a_box_range: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> box_ll_x <= box_ur_x && box_ll_y <= box_ur_y &&
            box_ll_x >= 0 && box_ll_y >= 0 &&
            box_ur_x <= screen_w && box_ur_y <= screen_h)
        else begin
            $error("box corners out of order or off screen");
            assert_fails++;
        end

endmodule

bind bbox_unit bbox_checker u_checker (
    .clk(clk), .rst(rst), .out_valid(out_valid), .out_ready(out_ready),
    .out_tri_x(out_tri_x), .out_tri_y(out_tri_y), .out_tri_z(out_tri_z),
    .out_color(out_color), .box_ll_x(box_ll_x), .box_ll_y(box_ll_y),
    .box_ur_x(box_ur_x), .box_ur_y(box_ur_y),
    .screen_w(screen_w), .screen_h(screen_h)
);

/* tests/bbox_tb.sv */
// Random triangles from a fixed seed, checked against a model of the box rules
// Screen is 64 by 48 pixels, configuration changes only while the unit is empty
// Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
// Latency is checked only while out_ready is held high
`timescale 1ns/1ps

module bbox_tb;
    import bbox_pkg::*;

    localparam int PIPE_DEPTH = 3;
    localparam int WAIT_LIMIT = 400;
    // One pixel in fixed point
    localparam int PX = 1 << RADIX;
    localparam int WORD_W = $bits(pipe_word_t);

    logic   clk;
    logic   rst;
    logic   in_valid;
    logic   in_ready;
    coord_t tri_x [VERTS];
    coord_t tri_y [VERTS];
    coord_t tri_z [VERTS];
    color_t color [COLORS];
    coord_t screen_w;
    coord_t screen_h;
    msaa_t  sample_mode;
    logic   out_valid;
    logic   out_ready;
    coord_t out_tri_x [VERTS];
    coord_t out_tri_y [VERTS];
    coord_t out_tri_z [VERTS];
    color_t out_color [COLORS];
    coord_t box_ll_x;
    coord_t box_ll_y;
    coord_t box_ur_x;
    coord_t box_ur_y;

    integer seed;
    int     cyc = 0;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_ok = 0;
    int     test_err_start;
    logic   ready_random = 1'b0;
    logic   check_latency = 1'b0;

    // Scoreboard and running counts
    pipe_word_t exp_q [$];
    int         cyc_q [$];
    int         kept_count = 0;
    int         reject_count = 0;
    int         clamp_count = 0;
    int         out_count = 0;
    int         stall_count = 0;
    logic       stall_prev = 1'b0;
    pipe_word_t snap;

    bbox_unit #(.PIPE_DEPTH(PIPE_DEPTH)) UUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
        .tri_x(tri_x), .tri_y(tri_y), .tri_z(tri_z), .color(color),
        .screen_w(screen_w), .screen_h(screen_h), .sample_mode(sample_mode),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_tri_x(out_tri_x), .out_tri_y(out_tri_y), .out_tri_z(out_tri_z),
        .out_color(out_color), .box_ll_x(box_ll_x), .box_ll_y(box_ll_y),
        .box_ur_x(box_ur_x), .box_ur_y(box_ur_y)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(string name, logic [WORD_W-1:0] got, logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic note_error(string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    // Scoreboard errors plus failed assertions of the bound checker
    function automatic int total_errors();
        return errors + UUT.u_checker.assert_fails;
    endfunction

    task automatic timeout_fail(string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("tests failed");
        $finish;
    endtask

    // Floor to the grid of the mode
    // 1x keeps no fraction bits and each finer mode keeps one more
    function automatic coord_t floor_grid(coord_t v, msaa_t mode);
        int keep_bits;
        keep_bits = (mode == MSAA_64X) ? 3 : (mode == MSAA_16X) ? 2 : (mode == MSAA_4X) ? 1 : 0;
        return (v >>> (RADIX - keep_bits)) <<< (RADIX - keep_bits);
    endfunction

    function automatic coord_t rand_coord(int lo_px, int span_px);
        int unsigned r;
        int          val;
        r = $random(seed);
        val = lo_px * PX + int'(r % (span_px * PX));
        return coord_t'(val);
    endfunction

    function automatic pipe_word_t pack_outputs();
        pipe_word_t w;
        for (int v = 0; v < VERTS; v++) begin
            w.tri_x[v] = out_tri_x[v];
            w.tri_y[v] = out_tri_y[v];
            w.tri_z[v] = out_tri_z[v];
        end
        for (int c = 0; c < COLORS; c++) w.color[c] = out_color[c];
        w.ll_x = box_ll_x;
        w.ll_y = box_ll_y;
        w.ur_x = box_ur_x;
        w.ur_y = box_ur_y;
        return w;
    endfunction

    // Model of one accepted triangle
    task automatic model_accept();
        pipe_word_t e;
        coord_t     lx;
        coord_t     ly;
        coord_t     ux;
        coord_t     uy;
        logic       clamped;
        lx = tri_x[0];
        ux = tri_x[0];
        ly = tri_y[0];
        uy = tri_y[0];
        for (int v = 0; v < VERTS; v++) begin
            e.tri_x[v] = tri_x[v];
            e.tri_y[v] = tri_y[v];
            e.tri_z[v] = tri_z[v];
            if (tri_x[v] < lx) lx = tri_x[v];
            if (tri_x[v] > ux) ux = tri_x[v];
            if (tri_y[v] < ly) ly = tri_y[v];
            if (tri_y[v] > uy) uy = tri_y[v];
        end
        for (int c = 0; c < COLORS; c++) e.color[c] = color[c];
        lx = floor_grid(lx, sample_mode);
        ly = floor_grid(ly, sample_mode);
        ux = floor_grid(ux, sample_mode);
        uy = floor_grid(uy, sample_mode);
        clamped = (lx < 0) || (ly < 0) || (ux > screen_w) || (uy > screen_h);
        e.ll_x = (lx < 0) ? coord_t'(0) : lx;
        e.ll_y = (ly < 0) ? coord_t'(0) : ly;
        e.ur_x = (ux > screen_w) ? screen_w : ux;
        e.ur_y = (uy > screen_h) ? screen_h : uy;
        // Box must overlap the screen on both axes
        if (e.ur_x > 0 && e.ur_y > 0 && e.ll_x < screen_w && e.ll_y < screen_h) begin
            exp_q.push_back(e);
            cyc_q.push_back(cyc);
            kept_count++;
            if (clamped) clamp_count++;
        end else begin
            reject_count++;
        end
    endtask

    // Pops the queue on each output transfer
    task automatic take_output();
        pipe_word_t got;
        pipe_word_t e;
        int         t_in;
        got = pack_outputs();
        out_count++;
        if (exp_q.size() == 0) begin
            note_error("output transfer with no kept triangle waiting");
        end else begin
            e = exp_q.pop_front();
            t_in = cyc_q.pop_front();
            for (int v = 0; v < VERTS; v++) begin
                check_value($sformatf("out_tri_x[%0d]", v), got.tri_x[v], e.tri_x[v]);
                check_value($sformatf("out_tri_y[%0d]", v), got.tri_y[v], e.tri_y[v]);
                check_value($sformatf("out_tri_z[%0d]", v), got.tri_z[v], e.tri_z[v]);
            end
            for (int c = 0; c < COLORS; c++) begin
                check_value($sformatf("out_color[%0d]", c), got.color[c], e.color[c]);
            end
            check_value("box_ll_x", got.ll_x, e.ll_x);
            check_value("box_ll_y", got.ll_y, e.ll_y);
            check_value("box_ur_x", got.ur_x, e.ur_x);
            check_value("box_ur_y", got.ur_y, e.ur_y);
            if (check_latency) check_value("latency", cyc - t_in, PIPE_DEPTH);
        end
    endtask

    // Output and input monitor
    // Falling edge sits clear of the drive and of register updates
    always @(negedge clk) begin
        if (!rst) begin
            if (stall_prev) begin
                if (!out_valid) note_error("out_valid dropped while the sink stalled");
                else check_value("stalled outputs", pack_outputs(), snap);
            end
            stall_prev = out_valid && !out_ready;
            if (stall_prev) begin
                snap = pack_outputs();
                stall_count++;
            end
            if (out_valid && out_ready) take_output();
            if (in_valid && in_ready) model_accept();
        end
    end

    // Every drive happens 1 ns after a rising edge
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        if (ready_random) begin
            rnd = $random(seed);
            out_ready = rnd[0];
        end
    endtask

    // Triangle of three vertices near a random center
    task automatic load_triangle(int c_lo, int c_span);
        coord_t cx;
        coord_t cy;
        cx = rand_coord(c_lo, c_span);
        cy = rand_coord(c_lo, c_span);
        for (int v = 0; v < VERTS; v++) begin
            tri_x[v] = cx + rand_coord(-8, 16);
            tri_y[v] = cy + rand_coord(-8, 16);
            tri_z[v] = rand_coord(-64, 128);
        end
        for (int c = 0; c < COLORS; c++) color[c] = color_t'($random(seed));
    endtask

    task automatic send_current();
        int   waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        in_valid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            next_cycle();
            waited++;
            if (!accepted && waited > WAIT_LIMIT) timeout_fail("input handshake never completed");
        end
        in_valid = 1'b0;
    endtask

    task automatic run_batch(msaa_t mode, int count, int c_lo, int c_span);
        sample_mode = mode;
        repeat (count) begin
            load_triangle(c_lo, c_span);
            send_current();
        end
    endtask

    // Waits for every kept triangle, then a few more cycles to catch extras
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) timeout_fail("kept triangles never left the unit");
        end
        repeat (PIPE_DEPTH + 1) next_cycle();
    endtask

    task automatic start_test();
        test_err_start = total_errors();
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (total_errors() == test_err_start) tests_ok++;
        $display("Test %0d %s: %s", tests_run, name,
                 (total_errors() == test_err_start) ? "ok" : "errors");
    endtask

    initial begin
        int kept0;
        int out0;
        int rej0;
        int clamp0;
        int stall0;
        seed = 32'h50be659e;
        rst = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b1;
        for (int v = 0; v < VERTS; v++) begin
            tri_x[v] = '0;
            tri_y[v] = '0;
            tri_z[v] = '0;
        end
        for (int c = 0; c < COLORS; c++) color[c] = '0;
        screen_w = coord_t'(64 * PX);
        screen_h = coord_t'(48 * PX);
        sample_mode = MSAA_1X;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test();
        @(negedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("in_ready", in_ready, 1'b1);
        next_cycle();
        end_test("reset state");

        start_test();
        check_latency = 1'b1;
        run_batch(MSAA_1X, 40, -16, 96);
        drain();
        check_latency = 1'b0;
        end_test("1x random with latency");

        start_test();
        run_batch(MSAA_4X, 30, -16, 96);
        drain();
        end_test("4x grid");

        start_test();
        run_batch(MSAA_16X, 30, -16, 96);
        drain();
        end_test("16x grid");

        start_test();
        run_batch(MSAA_64X, 30, -16, 96);
        drain();
        end_test("64x grid");

        // Wide centers push many boxes over the edges or fully off screen
        start_test();
        kept0 = kept_count;
        out0 = out_count;
        rej0 = reject_count;
        clamp0 = clamp_count;
        run_batch(MSAA_16X, 60, -64, 192);
        drain();
        check_value("output count", out_count - out0, kept_count - kept0);
        if (reject_count == rej0) note_error("no triangle was wholly off screen");
        if (clamp_count == clamp0) note_error("no kept triangle needed clamping");
        end_test("clamp and reject");

        start_test();
        kept0 = kept_count;
        out0 = out_count;
        stall0 = stall_count;
        ready_random = 1'b1;
        run_batch(MSAA_4X, 60, -16, 96);
        drain();
        ready_random = 1'b0;
        out_ready = 1'b1;
        check_value("output count", out_count - out0, kept_count - kept0);
        if (stall_count == stall0) note_error("sink never stalled the unit");
        end_test("random back-pressure");

        $display("Summary: %0d tests run, %0d clean, %0d errors",
                 tests_run, tests_ok, total_errors());
        if (total_errors() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* bbox.f */
logic/bbox_pkg.sv
logic/bbox_extent.sv
logic/bbox_clip.sv
logic/bbox_pipe.sv
logic/bbox_unit.sv
tests/bbox_checker.sv
tests/bbox_tb.sv

/* Bender.yml */
# Bounding-box stage of a rasterizer
package:
  name: bbox

sources:
  # Design, package first
  - logic/bbox_pkg.sv
  - logic/bbox_extent.sv
  - logic/bbox_clip.sv
  - logic/bbox_pipe.sv
  - logic/bbox_unit.sv

  # Testbench and bound checker, top module bbox_tb
  - target: test
    files:
      - tests/bbox_checker.sv
      - tests/bbox_tb.sv
